// ==== Makefile ====
TOP  = tb_box_overlay
SRCS = $(shell cat flist.f)

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module box_overlay_top $(filter logic/%,$(SRCS))

obj_dir/V$(TOP): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/overlay_input.txt ====
# W addr data | R addr expected_data expected_pslverr | F frames (hex values, decimal frames)
# Box i at i*16: X at +0, Y at +4, COLOR at +8, CTRL at +c
R 00 00000000 0
R 18 00000000 0
R 3c 00000000 0
F 1
W 00 f00af004
W 04 00080002
W 08 00ff0000
W 0c 00000001
R 00 000a0004 0
R 04 00080002 0
R 08 00ff0000 0
R 0c 00000001 0
W 44 ffffffff
R 44 00000000 1
R 00 000a0004 0
F 2
W 10 00140008
W 14 000c0005
W 18 0000ff00
W 1c 00000001
W 20 001f0000
W 24 000f0000
W 28 000000ff
F 2
W 00 00100006
F 2
W 30 001f0000
W 34 000f0000
W 38 00ffffff
W 3c 00000001
F 2

// ==== dv/tb_box_overlay.sv ====
`default_nettype none

module tb_box_overlay;
    timeunit 1ns;
    timeprecision 1ps;

    import overlay_pkg::*;

    localparam int H_ACT       = 32;
    localparam int H_FP        = 2;
    localparam int H_SYNC      = 3;
    localparam int H_BP        = 3;
    localparam int V_ACT       = 16;
    localparam int V_FP        = 1;
    localparam int V_SYNC      = 2;
    localparam int V_BP        = 2;
    localparam int N_BOX       = 4;
    localparam int BORDER_W    = 2;
    localparam int LINE_LEN    = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int FRAME_LINES = V_ACT + V_FP + V_SYNC + V_BP;
    localparam int FRAME_BOUND = 25 * 41;   // 21 lines of 40 cycles plus margin

    logic     pix_clk;
    logic     rst_n;
    apb_req_t apb;
    apb_rsp_t rsp;
    pix_t     dut_pix;

    box_t staged_m [N_BOX];   // What software has written
    box_t shadow_m [N_BOX];   // What the overlay is drawing
    box_t hist1    [N_BOX];   // Staged model one and two cycles back
    box_t hist2    [N_BOX];
    int   x_pos;
    int   y_pos;
    int   h_tick;             // Output cycles since the start of the active line
    int   v_line;
    logic prev_de;
    logic seen_sof;
    logic check_on;
    int   sof_cnt;
    int   cycles;
    int   limit;

    box_overlay_top #(
        .N_BOX    (N_BOX),
        .BORDER_W (BORDER_W),
        .H_ACT    (H_ACT),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACT    (V_ACT),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) i_dut (
        .pix_clk (pix_clk),
        .i_rst_n (rst_n),
        .i_apb   (apb),
        .o_apb   (rsp),
        .o_pix   (dut_pix)
    );

    always #5 pix_clk = ~pix_clk;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic open_input(output int fd);
        fd = $fopen("dv/overlay_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/overlay_input.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stimulus file missing");
        end
    endtask

    // Setup then access cycle with the response sampled mid access
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        @(posedge pix_clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= wr;
        apb.paddr   <= addr;
        apb.pwdata  <= wdata;
        @(posedge pix_clk);
        apb.penable <= 1'b1;
        @(negedge pix_clk);
        rdata  = rsp.prdata;
        slverr = rsp.pslverr;
        check_val("apb pready", 32'h1, {31'h0, rsp.pready});
        @(posedge pix_clk);
        apb <= '0;
    endtask

    // Lands on the same edge as the DUT write
    task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
        int idx;
        idx = int'(addr) / 16;
        if (idx < N_BOX) begin
            case (reg_sel_e'(addr[3:2]))
                REG_X: begin
                    staged_m[idx].x0 <= data[11:0];
                    staged_m[idx].x1 <= data[27:16];
                end
                REG_Y: begin
                    staged_m[idx].y0 <= data[11:0];
                    staged_m[idx].y1 <= data[27:16];
                end
                REG_COLOR: staged_m[idx].color <= data[23:0];
                REG_CTRL:  staged_m[idx].en <= data[0];
            endcase
        end
    endtask

    function automatic logic [23:0] expect_rgb(input int x, input int y);
        logic [7:0]  r;
        logic [7:0]  g;
        logic [23:0] rgb;
        int          x0;
        int          x1;
        int          y0;
        int          y1;
        logic        outer;
        logic        inner;
        r   = x[7:0];
        g   = y[7:0];
        rgb = {r, g, r ^ g};
        for (int i = 0; i < N_BOX; i++) begin
            x0    = int'(shadow_m[i].x0);
            x1    = int'(shadow_m[i].x1);
            y0    = int'(shadow_m[i].y0);
            y1    = int'(shadow_m[i].y1);
            outer = x >= x0 && x <= x1 && y >= y0 && y <= y1;
            inner = x >= x0 + BORDER_W && x <= x1 - BORDER_W &&
                    y >= y0 + BORDER_W && y <= y1 - BORDER_W;
            if (shadow_m[i].en && outer && !inner) begin
                rgb = shadow_m[i].color;   // Later box overrides
            end
        end
        return rgb;
    endfunction

    // Expected {hsync, vsync, de} at a position counted from sof
    function automatic logic [2:0] expect_ctrl(input int h, input int v);
        int   row;
        logic hs;
        logic vs;
        logic de;
        row = v;
        if (h >= H_ACT + H_FP) begin
            row = v + 1;   // Next line starts with its hsync
        end
        row = row % FRAME_LINES;
        hs  = h >= H_ACT + H_FP && h < H_ACT + H_FP + H_SYNC;
        vs  = row >= V_ACT + V_FP && row < V_ACT + V_FP + V_SYNC;
        de  = h < H_ACT && v < V_ACT;
        return {hs, vs, de};
    endfunction

    // Output pixel monitor with the shadow reload seen two cycles after the DUT
    always @(posedge pix_clk) begin
        if (rst_n) begin
            if (dut_pix.sof) begin
                if (check_on && seen_sof) begin
                    check_val("lines per frame", V_ACT, y_pos);
                end
                seen_sof = 1'b1;
                shadow_m = hist2;
                x_pos    = 0;
                y_pos    = 0;
                h_tick   = 0;
                v_line   = 0;
                sof_cnt <= sof_cnt + 1;
            end else if (seen_sof) begin
                h_tick++;
                if (h_tick == LINE_LEN) begin
                    h_tick = 0;
                    v_line++;
                end
            end
            if (check_on && seen_sof) begin
                check_val($sformatf("sync and de at (%0d,%0d)", h_tick, v_line),
                          expect_ctrl(h_tick, v_line),
                          {dut_pix.hsync, dut_pix.vsync, dut_pix.de});
            end
            if (dut_pix.de) begin
                if (check_on) begin
                    check_val($sformatf("pixel (%0d,%0d)", x_pos, y_pos),
                              expect_rgb(x_pos, y_pos), {dut_pix.r, dut_pix.g, dut_pix.b});
                end
                x_pos++;
            end else begin
                if (check_on) begin
                    check_val("blanking colour", 32'h0, {dut_pix.r, dut_pix.g, dut_pix.b});
                end
                if (prev_de) begin
                    if (check_on) begin
                        check_val("pixels per line", H_ACT, x_pos);
                    end
                    y_pos++;
                    x_pos = 0;
                end
            end
            prev_de = dut_pix.de;
            hist2   = hist1;
            hist1   = staged_m;
        end
    end

    always @(posedge pix_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, the expected frames never arrived", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Cycle limit reached");
        end
    end

    initial begin
        int          fd;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_err;
        logic [31:0] rdata;
        logic        slverr;
        int          frames;
        int          target;
        int          n_cmd;
        int          n_frames;
        pix_clk  = 1'b0;
        rst_n    = 1'b0;
        apb      = '0;
        check_on = 1'b0;
        seen_sof = 1'b0;
        prev_de  = 1'b0;
        sof_cnt  = 0;
        cycles   = 0;
        limit    = 32'h7fff_ffff;
        x_pos    = 0;
        y_pos    = 0;
        h_tick   = 0;
        v_line   = 0;
        n_cmd    = 0;
        n_frames = 0;
        for (int i = 0; i < N_BOX; i++) begin
            staged_m[i] = '0;
            shadow_m[i] = '0;
            hist1[i]    = '0;
            hist2[i]    = '0;
        end

        // First pass only sizes the run
        open_input(fd);
        while ($fgets(line, fd) > 0) begin
            cmd = line.getc(0);
            if (cmd == "W" || cmd == "R" || cmd == "F") begin
                n_cmd++;
            end
            if (cmd == "F") begin
                void'($sscanf(line, "F %d", frames));
                n_frames += frames;
            end
        end
        $fclose(fd);
        limit = n_cmd * 10 + (n_frames + 2) * FRAME_BOUND;

        repeat (8) @(posedge pix_clk);
        rst_n <= 1'b1;

        open_input(fd);
        while ($fgets(line, fd) > 0) begin
            cmd = line.getc(0);
            case (cmd)
                "W": begin
                    void'($sscanf(line, "W %h %h", addr, data));
                    apb_access(1'b1, addr[7:0], data, rdata, slverr);
                    model_write(addr[7:0], data);
                    check_val($sformatf("write %02h pslverr", addr[7:0]),
                              {31'h0, addr >= N_BOX * 16}, {31'h0, slverr});
                end
                "R": begin
                    void'($sscanf(line, "R %h %h %h", addr, data, exp_err));
                    apb_access(1'b0, addr[7:0], 32'h0, rdata, slverr);
                    check_val($sformatf("read %02h data", addr[7:0]), data, rdata);
                    check_val($sformatf("read %02h pslverr", addr[7:0]), exp_err, {31'h0, slverr});
                end
                "F": begin
                    void'($sscanf(line, "F %d", frames));
                    target = sof_cnt + frames + (check_on ? 0 : 1);
                    check_on <= 1'b1;
                    while (sof_cnt < target) begin
                        @(posedge pix_clk);
                    end
                end
                "#", " ", "\t", "\r", "\n", 8'h00: begin
                end
                default: begin
                    $display("Unknown command in the stimulus file: %s", line);
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "Bad stimulus file");
                end
            endcase
        end
        $fclose(fd);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/overlay_pkg.sv
logic/video_timing_gen.sv
logic/box_cfg_regs.sv
logic/box_overlay.sv
logic/box_overlay_top.sv
dv/tb_box_overlay.sv

// ==== logic/box_cfg_regs.sv ====
`default_nettype none

module box_cfg_regs #(
    parameter int N_BOX = 4
) (
    input  wire                        pix_clk,
    input  wire                        i_rst_n,
    input  wire overlay_pkg::apb_req_t i_apb,
    output overlay_pkg::apb_rsp_t      o_apb,
    input  wire                        i_frame_start,
    output overlay_pkg::box_t          o_boxes [N_BOX]
);
    import overlay_pkg::*;

    localparam int IDX_W = (N_BOX > 1) ? $clog2(N_BOX) : 1;

    box_t             staged [N_BOX];   // Software view
    box_t             shadow [N_BOX];   // Overlay view, frame aligned
    reg_sel_e         sel;
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             wr_en;
    logic [31:0]      rd_word;

    function automatic logic [31:0] pair_word(input logic [COORD_W-1:0] lo,
                                              input logic [COORD_W-1:0] hi);
        logic [31:0] word;
        word                    = '0;
        word[COORD_W-1:0]       = lo;
        word[HI_LSB +: COORD_W] = hi;
        return word;
    endfunction

    assign sel      = reg_sel_e'(i_apb.paddr[3:2]);
    assign idx      = i_apb.paddr[BOX_IDX_LSB +: IDX_W];
    assign in_range = int'(i_apb.paddr) < N_BOX * BOX_BYTES;
    assign wr_en    = i_apb.psel && i_apb.penable && i_apb.pwrite && in_range;

    always_ff @(posedge pix_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_BOX; i++) begin
                staged[i] <= '0;
                shadow[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                case (sel)
                    REG_X: begin
                        staged[idx].x0 <= i_apb.pwdata[COORD_W-1:0];
                        staged[idx].x1 <= i_apb.pwdata[HI_LSB +: COORD_W];
                    end
                    REG_Y: begin
                        staged[idx].y0 <= i_apb.pwdata[COORD_W-1:0];
                        staged[idx].y1 <= i_apb.pwdata[HI_LSB +: COORD_W];
                    end
                    REG_COLOR: begin
                        staged[idx].color <= i_apb.pwdata[23:0];
                    end
                    REG_CTRL: begin
                        staged[idx].en <= i_apb.pwdata[CTRL_EN];
                    end
                endcase
            end
            // Same-cycle write lands in staged only, shadow takes the old value
            if (i_frame_start) begin
                shadow <= staged;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (in_range) begin
            case (sel)
                REG_X:     rd_word = pair_word(staged[idx].x0, staged[idx].x1);
                REG_Y:     rd_word = pair_word(staged[idx].y0, staged[idx].y1);
                REG_COLOR: rd_word[23:0] = staged[idx].color;
                REG_CTRL:  rd_word[CTRL_EN] = staged[idx].en;
            endcase
        end
    end

    // No wait states
    assign o_apb.prdata  = i_apb.psel ? rd_word : 32'h0;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = i_apb.psel && i_apb.penable && !in_range;

    assign o_boxes = shadow;

    a_penable_psel: assert property (@(posedge pix_clk) disable iff (!i_rst_n)
        i_apb.penable |-> i_apb.psel);

    // Setup to access, address held
    a_paddr_stable: assert property (@(posedge pix_clk) disable iff (!i_rst_n)
        i_apb.psel && !i_apb.penable |=> $stable(i_apb.paddr));

endmodule

`default_nettype wire

// ==== logic/box_overlay.sv ====
`default_nettype none

module box_overlay #(
    parameter int N_BOX    = 4,
    parameter int BORDER_W = 1
) (
    input  wire                    pix_clk,
    input  wire                    i_rst_n,
    input  wire overlay_pkg::pix_t i_pix,
    input  wire overlay_pkg::pos_t i_pos,
    input  wire overlay_pkg::box_t i_boxes [N_BOX],
    output overlay_pkg::pix_t      o_pix
);
    import overlay_pkg::*;

    // One extra bit so x+BW cannot wrap
    localparam logic [COORD_W:0] BW = (COORD_W + 1)'(BORDER_W);

    logic [N_BOX-1:0] hit;
    logic [COORD_W:0] px;
    logic [COORD_W:0] py;
    logic [23:0]      out_rgb;

    assign px = {1'b0, i_pos.x};
    assign py = {1'b0, i_pos.y};

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        logic [COORD_W:0] x0;
        logic [COORD_W:0] x1;
        logic [COORD_W:0] y0;
        logic [COORD_W:0] y1;
        logic             outer;
        logic             inner;

        assign x0 = {1'b0, i_boxes[i].x0};
        assign x1 = {1'b0, i_boxes[i].x1};
        assign y0 = {1'b0, i_boxes[i].y0};
        assign y1 = {1'b0, i_boxes[i].y1};

        assign outer = i_boxes[i].en && (px >= x0) && (px <= x1) && (py >= y0) && (py <= y1);
        // Interior left untouched
        assign inner = (px >= x0 + BW) && (px + BW <= x1) && (py >= y0 + BW) && (py + BW <= y1);

        assign hit[i] = outer && !inner;
    end

    always_comb begin
        out_rgb = {i_pix.r, i_pix.g, i_pix.b};
        for (int i = 0; i < N_BOX; i++) begin
            if (hit[i]) begin
                out_rgb = i_boxes[i].color;   // Highest index wins
            end
        end
    end

    always_ff @(posedge pix_clk) begin
        if (!i_rst_n) begin
            o_pix <= '0;
        end else begin
            o_pix.hsync                <= i_pix.hsync;
            o_pix.vsync                <= i_pix.vsync;
            o_pix.de                   <= i_pix.de;
            o_pix.sof                  <= i_pix.sof;
            {o_pix.r, o_pix.g, o_pix.b} <= i_pix.de ? out_rgb : 24'h0;
        end
    end

    // Blanking input comes out black one cycle later
    a_blank_black: assert property (@(posedge pix_clk) disable iff (!i_rst_n)
        !i_pix.de |=> {o_pix.r, o_pix.g, o_pix.b} == 24'h0);

endmodule

`default_nettype wire

// ==== logic/box_overlay_top.sv ====
`default_nettype none

module box_overlay_top #(
    parameter int N_BOX    = 4,
    parameter int BORDER_W = 1,
    parameter int H_ACT    = 1280,
    parameter int H_FP     = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BP     = 220,
    parameter int V_ACT    = 720,
    parameter int V_FP     = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BP     = 20
) (
    input  wire                        pix_clk,
    input  wire                        i_rst_n,
    input  wire overlay_pkg::apb_req_t i_apb,
    output overlay_pkg::apb_rsp_t      o_apb,
    output overlay_pkg::pix_t          o_pix
);
    import overlay_pkg::*;

    pix_t gen_pix;
    pos_t gen_pos;
    logic frame_start;   // One cycle ahead of sof
    box_t boxes [N_BOX];

    video_timing_gen #(
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP)
    ) u_timing (
        .pix_clk       (pix_clk),
        .i_rst_n       (i_rst_n),
        .o_pix         (gen_pix),
        .o_pos         (gen_pos),
        .o_frame_start (frame_start)
    );

    box_cfg_regs #(
        .N_BOX (N_BOX)
    ) u_regs (
        .pix_clk       (pix_clk),
        .i_rst_n       (i_rst_n),
        .i_apb         (i_apb),
        .o_apb         (o_apb),
        .i_frame_start (frame_start),
        .o_boxes       (boxes)
    );

    box_overlay #(
        .N_BOX    (N_BOX),
        .BORDER_W (BORDER_W)
    ) u_overlay (
        .pix_clk (pix_clk),
        .i_rst_n (i_rst_n),
        .i_pix   (gen_pix),
        .i_pos   (gen_pos),
        .i_boxes (boxes),
        .o_pix   (o_pix)
    );

endmodule

`default_nettype wire

// ==== logic/overlay_pkg.sv ====
`default_nettype none

package overlay_pkg;

    localparam int COORD_W = 12;

    // Register map
    localparam int BOX_BYTES   = 16;   // Address stride per box
    localparam int BOX_IDX_LSB = 4;
    localparam int HI_LSB      = 16;   // x1 / y1 field in the X and Y words
    localparam int CTRL_EN     = 0;

    // Word select inside one box, paddr[3:2]
    typedef enum logic [1:0] {
        REG_X     = 2'd0,
        REG_Y     = 2'd1,
        REG_COLOR = 2'd2,
        REG_CTRL  = 2'd3
    } reg_sel_e;

    // Shared by both axes of the timing generator
    typedef enum logic [1:0] {
        PH_SYNC   = 2'd0,
        PH_BACK   = 2'd1,
        PH_ACTIVE = 2'd2,
        PH_FRONT  = 2'd3
    } line_phase_e;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic       sof;     // First active pixel of a frame
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pix_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } pos_t;

    typedef struct packed {
        logic               en;
        logic [COORD_W-1:0] x0;
        logic [COORD_W-1:0] x1;
        logic [COORD_W-1:0] y0;
        logic [COORD_W-1:0] y1;
        logic [23:0]        color;   // r,g,b from the top byte down
    } box_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/video_timing_gen.sv ====
`default_nettype none

module video_timing_gen #(
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 110,
    parameter int H_SYNC = 40,
    parameter int H_BP   = 220,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 5,
    parameter int V_SYNC = 5,
    parameter int V_BP   = 20
) (
    input  wire               pix_clk,
    input  wire               i_rst_n,
    output overlay_pkg::pix_t o_pix,
    output overlay_pkg::pos_t o_pos,
    output logic              o_frame_start
);
    import overlay_pkg::*;

    line_phase_e        h_phase;
    line_phase_e        v_phase;
    logic [COORD_W-1:0] h_cnt;   // Position inside the current phase
    logic [COORD_W-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    logic               line_end;
    logic               de_c;
    logic               sof_c;
    logic               pre_sof;

    function automatic int phase_len(input line_phase_e ph, input logic vert);
        int n;
        case (ph)
            PH_SYNC:   n = vert ? V_SYNC : H_SYNC;
            PH_BACK:   n = vert ? V_BP   : H_BP;
            PH_ACTIVE: n = vert ? V_ACT  : H_ACT;
            default:   n = vert ? V_FP   : H_FP;
        endcase
        return n;
    endfunction

    function automatic line_phase_e next_phase(input line_phase_e ph);
        case (ph)
            PH_SYNC:   return PH_BACK;
            PH_BACK:   return PH_ACTIVE;
            PH_ACTIVE: return PH_FRONT;
            default:   return PH_SYNC;
        endcase
    endfunction

    assign h_last   = int'(h_cnt) == phase_len(h_phase, 1'b0) - 1;
    assign v_last   = int'(v_cnt) == phase_len(v_phase, 1'b1) - 1;
    assign line_end = h_last && (h_phase == PH_FRONT);

    always_ff @(posedge pix_clk) begin
        if (!i_rst_n) begin
            h_phase <= PH_SYNC;
            v_phase <= PH_SYNC;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            if (h_last) begin
                h_phase <= next_phase(h_phase);
                h_cnt   <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            // Vertical steps once per line
            if (line_end) begin
                if (v_last) begin
                    v_phase <= next_phase(v_phase);
                    v_cnt   <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end
        end
    end

    assign de_c    = (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);
    assign sof_c   = de_c && (h_cnt == '0) && (v_cnt == '0);
    // Last blanking cycle before pixel (0,0)
    assign pre_sof = (h_phase == PH_BACK) && h_last && (v_phase == PH_ACTIVE) && (v_cnt == '0);

    always_ff @(posedge pix_clk) begin
        if (!i_rst_n) begin
            o_pix         <= '0;
            o_pos         <= '0;
            o_frame_start <= 1'b0;
        end else begin
            o_pix.hsync   <= (h_phase == PH_SYNC);
            o_pix.vsync   <= (v_phase == PH_SYNC);
            o_pix.de      <= de_c;
            o_pix.sof     <= sof_c;
            o_pix.r       <= de_c ? h_cnt[7:0] : 8'h00;
            o_pix.g       <= de_c ? v_cnt[7:0] : 8'h00;
            o_pix.b       <= de_c ? (h_cnt[7:0] ^ v_cnt[7:0]) : 8'h00;
            o_pos.x       <= h_cnt;   // Only meaningful while de is high
            o_pos.y       <= v_cnt;
            o_frame_start <= pre_sof;
        end
    end

    a_no_de_in_sync: assert property (@(posedge pix_clk) disable iff (!i_rst_n)
        $rose(o_pix.de) |-> !o_pix.hsync && !o_pix.vsync);

    a_frame_start_sof: assert property (@(posedge pix_clk) disable iff (!i_rst_n)
        o_frame_start |=> o_pix.sof);

endmodule

`default_nettype wire
